// File: source/vmul_config.svh
`ifndef VMUL_CONFIG_SVH
`define VMUL_CONFIG_SVH

// lanes per transfer.
`define VMUL_PARALLEL 4

// operand and result width.
`define VMUL_DIN_WIDTH 16

// full product width.
`define VMUL_PROD_WIDTH 32

// common binary point, fraction bits.
`define VMUL_ALIGN_FRAC 12

// result fifo entries, also the credit limit.
`define VMUL_QUEUE_DEPTH 8

`endif

// File: source/fixed_point_pkg.sv
`include "vmul_config.svh"

package fixed_point_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane scalars.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // input operand, point set per vector.
    typedef logic signed [`VMUL_DIN_WIDTH-1:0] operand_t;

    // product of two Q.12 values, so Q.24.
    typedef logic signed [`VMUL_PROD_WIDTH-1:0] product_t;

    // requantized output, Q.12.
    typedef logic signed [`VMUL_DIN_WIDTH-1:0] result_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lane vectors, lane 0 in the low bits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef operand_t [`VMUL_PARALLEL-1:0] operand_vec_t;
    typedef product_t [`VMUL_PARALLEL-1:0] product_vec_t;
    typedef result_t [`VMUL_PARALLEL-1:0] result_vec_t;

endpackage

// File: source/vmul_ctrl_pkg.sv
package vmul_ctrl_pkg;

    // fraction bit count of an input vector, 0 to 15.
    typedef logic [3:0] point_t;

    // requantize mode for the Q.24 product.
    // op_round adds half an lsb before the arithmetic shift.
    // op_trunc shifts only, so it rounds toward minus infinity.
    typedef enum logic {
        op_round = 1'b0,
        op_trunc = 1'b1
    } round_op_e;

endpackage

// File: source/point_align.sv
`timescale 1ns/1ns

`include "vmul_config.svh"

module point_align (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         in_valid,
    input  logic                         in_ready,
    input  fixed_point_pkg::operand_vec_t in_a,
    input  fixed_point_pkg::operand_vec_t in_b,
    input  vmul_ctrl_pkg::point_t        a_point,
    input  vmul_ctrl_pkg::point_t        b_point,
    input  vmul_ctrl_pkg::round_op_e     op,
    output logic                         al_valid,
    output fixed_point_pkg::operand_vec_t al_a,
    output fixed_point_pkg::operand_vec_t al_b,
    output vmul_ctrl_pkg::round_op_e     al_op
);
    import fixed_point_pkg::*;
    import vmul_ctrl_pkg::*;

    localparam int W      = `VMUL_DIN_WIDTH;
    localparam int FRAC   = `VMUL_ALIGN_FRAC;
    localparam int WIDE_W = W + FRAC;

    localparam logic signed [WIDE_W-1:0] OP_MAX = (1 <<< (W - 1)) - 1;
    localparam logic signed [WIDE_W-1:0] OP_MIN = -(1 <<< (W - 1));

    logic         accept;
    operand_vec_t a_aligned;
    operand_vec_t b_aligned;

    // move one value to Q.12.
    function automatic operand_t align(input operand_t v, input point_t pt);
        logic signed [WIDE_W-1:0] wide;
        wide = v;
        if (pt < FRAC) begin
            wide = wide <<< (FRAC - pt);
            if (wide > OP_MAX)
                return OP_MAX[W-1:0];
            if (wide < OP_MIN)
                return OP_MIN[W-1:0];
            return wide[W-1:0];
        end
        return v >>> (pt - FRAC);
    endfunction

    assign accept = in_valid & in_ready;

    always_comb begin
        for (int i = 0; i < `VMUL_PARALLEL; i++) begin
            a_aligned[i] = align(in_a[i], a_point);
            b_aligned[i] = align(in_b[i], b_point);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            al_valid <= 1'b0;
        else
            al_valid <= accept;
    end

    // idle cycles feed zeros into the multipliers.
    always_ff @(posedge clk) begin
        if (accept) begin
            al_a  <= a_aligned;
            al_b  <= b_aligned;
            al_op <= op;
        end else begin
            al_a <= '0;
            al_b <= '0;
        end
    end

endmodule

// File: source/dsp48_mult.sv
`timescale 1ns/1ns

module dsp48_mult (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      din_valid,
    input  fixed_point_pkg::operand_t din1,
    input  fixed_point_pkg::operand_t din2,
    output fixed_point_pkg::product_t dout,
    output logic                      dout_valid
);
    import fixed_point_pkg::*;

    // a and b input regs, m and p output regs.
    operand_t din1_r0;
    operand_t din1_r1;
    operand_t din2_r0;
    operand_t din2_r1;
    product_t prod_r0;
    product_t prod_r1;

    logic [3:0] valid_sr;

    assign dout       = prod_r1;
    assign dout_valid = valid_sr[3];

    always_ff @(posedge clk) begin
        if (!rst_n)
            valid_sr <= '0;
        else
            valid_sr <= {valid_sr[2:0], din_valid};
    end

    always_ff @(posedge clk) begin
        din1_r0 <= din_valid ? din1 : '0;
        din2_r0 <= din_valid ? din2 : '0;
        din1_r1 <= din1_r0;
        din2_r1 <= din2_r0;
        prod_r0 <= din1_r1 * din2_r1;
        prod_r1 <= prod_r0;
    end

endmodule

// File: source/parallel_mult.sv
`timescale 1ns/1ns

`include "vmul_config.svh"

module parallel_mult (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          din_valid,
    input  fixed_point_pkg::operand_vec_t din1,
    input  fixed_point_pkg::operand_vec_t din2,
    output fixed_point_pkg::product_vec_t dout,
    output logic                          dout_valid
);

    logic [`VMUL_PARALLEL-1:0] lane_valid;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // one multiplier per lane.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    for (genvar i = 0; i < `VMUL_PARALLEL; i++) begin : g_lane
        dsp48_mult dsp48_mult_i (
            .clk        (clk),
            .rst_n      (rst_n),
            .din_valid  (din_valid),
            .din1       (din1[i]),
            .din2       (din2[i]),
            .dout       (dout[i]),
            .dout_valid (lane_valid[i])
        );
    end

    // lanes run in lockstep, so this is lane 0's valid.
    assign dout_valid = &lane_valid;

endmodule

// File: source/result_queue.sv
`timescale 1ns/1ns

`include "vmul_config.svh"

module result_queue (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          al_valid,
    input  vmul_ctrl_pkg::round_op_e      al_op,
    input  logic                          prod_valid,
    input  fixed_point_pkg::product_vec_t prod,
    output logic                          in_ready,
    output logic                          out_valid,
    input  logic                          out_ready,
    output fixed_point_pkg::result_vec_t  out_data
);
    import fixed_point_pkg::*;
    import vmul_ctrl_pkg::*;

    localparam int QD    = `VMUL_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(QD);
    localparam int CNT_W = $clog2(QD + 1);
    localparam int PW    = `VMUL_PROD_WIDTH;
    localparam int RW    = `VMUL_DIN_WIDTH;
    localparam int DROP  = `VMUL_ALIGN_FRAC;

    localparam logic signed [PW:0] HALF    = 1 <<< (DROP - 1);
    localparam logic signed [PW:0] RES_MAX = (1 <<< (RW - 1)) - 1;
    localparam logic signed [PW:0] RES_MIN = -(1 <<< (RW - 1));

    round_op_e        op_mem [QD];
    logic [PTR_W-1:0] op_wr_ptr;
    logic [PTR_W-1:0] op_rd_ptr;
    round_op_e        head_op;

    result_vec_t      rq_data;
    logic             rq_valid;

    result_vec_t      fifo_mem [QD];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_count;
    logic [CNT_W-1:0] inflight;
    logic [CNT_W:0]   credit_used;
    logic             pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
        return (p == PTR_W'(QD - 1)) ? '0 : p + 1'b1;
    endfunction

    // Q.24 down to Q.12, then clamp.
    function automatic result_t requant(input product_t p, input round_op_e rop);
        logic signed [PW:0] biased;
        logic signed [PW:0] shifted;
        biased = p;
        if (rop == op_round)
            biased = biased + HALF;
        shifted = biased >>> DROP;
        if (shifted > RES_MAX)
            return RES_MAX[RW-1:0];
        if (shifted < RES_MIN)
            return RES_MIN[RW-1:0];
        return shifted[RW-1:0];
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // opcode side queue, order matches pipe.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (al_valid)
            op_mem[op_wr_ptr] <= al_op;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            op_wr_ptr <= '0;
            op_rd_ptr <= '0;
        end else begin
            if (al_valid)
                op_wr_ptr <= next_ptr(op_wr_ptr);
            if (prod_valid)
                op_rd_ptr <= next_ptr(op_rd_ptr);
        end
    end

    assign head_op = op_mem[op_rd_ptr];

    // requantize stage.
    always_ff @(posedge clk) begin
        if (!rst_n)
            rq_valid <= 1'b0;
        else
            rq_valid <= prod_valid;
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            for (int i = 0; i < `VMUL_PARALLEL; i++)
                rq_data[i] <= requant(prod[i], head_op);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result fifo and credits.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign pop       = out_valid & out_ready;
    assign out_valid = (fifo_count != '0);
    assign out_data  = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rq_valid)
            fifo_mem[wr_ptr] <= rq_data;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
            inflight   <= '0;
        end else begin
            if (rq_valid)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            fifo_count <= fifo_count + CNT_W'(rq_valid) - CNT_W'(pop);
            inflight   <= inflight + CNT_W'(al_valid) - CNT_W'(rq_valid);
        end
    end

    // al_valid covers the transfer accepted on the last edge.
    assign credit_used = fifo_count + inflight + (CNT_W + 1)'(al_valid);
    assign in_ready    = (credit_used < QD);

endmodule

// File: source/vmul_top.sv
`timescale 1ns/1ns

module vmul_top (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  fixed_point_pkg::operand_vec_t in_a,
    input  fixed_point_pkg::operand_vec_t in_b,
    input  vmul_ctrl_pkg::point_t         a_point,
    input  vmul_ctrl_pkg::point_t         b_point,
    input  vmul_ctrl_pkg::round_op_e      op,
    output logic                          out_valid,
    input  logic                          out_ready,
    output fixed_point_pkg::result_vec_t  out_data
);
    import fixed_point_pkg::*;
    import vmul_ctrl_pkg::*;

    logic         al_valid;
    operand_vec_t al_a;
    operand_vec_t al_b;
    round_op_e    al_op;
    logic         prod_valid;
    product_vec_t prod;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // align, multiply, requantize.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    point_align point_align_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_a     (in_a),
        .in_b     (in_b),
        .a_point  (a_point),
        .b_point  (b_point),
        .op       (op),
        .al_valid (al_valid),
        .al_a     (al_a),
        .al_b     (al_b),
        .al_op    (al_op)
    );

    parallel_mult parallel_mult_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .din_valid  (al_valid),
        .din1       (al_a),
        .din2       (al_b),
        .dout       (prod),
        .dout_valid (prod_valid)
    );

    // owns the credit count, so it drives in_ready.
    result_queue result_queue_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .al_valid   (al_valid),
        .al_op      (al_op),
        .prod_valid (prod_valid),
        .prod       (prod),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_data   (out_data)
    );

endmodule

// File: sim/vmul_assertions.sv
`timescale 1ns/1ns

module vmul_assertions (
    input logic                          clk,
    input logic                          rst_n,
    input logic                          in_valid,
    input logic                          in_ready,
    input fixed_point_pkg::operand_vec_t in_a,
    input fixed_point_pkg::operand_vec_t in_b,
    input vmul_ctrl_pkg::point_t         a_point,
    input vmul_ctrl_pkg::point_t         b_point,
    input vmul_ctrl_pkg::round_op_e      op,
    input logic                          out_valid,
    input logic                          out_ready,
    input fixed_point_pkg::result_vec_t  out_data
);

    // a waiting transfer keeps its payload.
    property input_held;
        @(posedge clk) disable iff (!rst_n)
        (in_valid && !in_ready) |=> (in_valid && $stable(in_a) && $stable(in_b)
            && $stable(a_point) && $stable(b_point) && $stable(op));
    endproperty

    property output_held;
        @(posedge clk) disable iff (!rst_n)
        (out_valid && !out_ready) |=> (out_valid && $stable(out_data));
    endproperty

    // pipeline is six deep, nothing can leave earlier.
    property quiet_after_reset;
        @(posedge clk) $rose(rst_n) |-> !out_valid [*6];
    endproperty

    input_held_a: assert property (input_held)
        else $error("input transfer changed before it was accepted");
    output_held_a: assert property (output_held)
        else $error("output transfer changed before it was taken");
    quiet_after_reset_a: assert property (quiet_after_reset)
        else $error("out_valid rose within six cycles of reset");

endmodule

// File: sim/vmul_tb.sv
`timescale 1ns/1ns

`include "vmul_config.svh"

module vmul_tb;
    import fixed_point_pkg::*;
    import vmul_ctrl_pkg::*;

    localparam int TIMEOUT_CYCLES = 4000;
    localparam int DRAIN_CYCLES   = 64;
    localparam int MODE_SMALL     = 0;
    localparam int MODE_POINTS    = 1;
    localparam int MODE_LARGE     = 2;

    logic         clk, rst_n;
    logic         in_valid, in_ready;
    operand_vec_t in_a, in_b;
    point_t       a_point, b_point;
    round_op_e    op;
    logic         out_valid, out_ready;
    result_vec_t  out_data;

    integer       seed = 94;
    result_vec_t  exp_q[$];
    result_vec_t  expected;
    logic         took;
    logic         repeat_pair;
    int           cycle_count, value_errors, other_errors, stall_cycles, latency;

    vmul_top dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_a      (in_a),
        .in_b      (in_b),
        .a_point   (a_point),
        .b_point   (b_point),
        .op        (op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data)
    );

    bind vmul_top vmul_assertions assertions_i (.*);

    initial clk = 1'b0;
    always #4 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // division rounding toward minus infinity, d > 0.
    function automatic longint floor_div(input longint n, input longint d);
        longint q;
        q = n / d;
        if ((n % d != 0) && (n < 0))
            q = q - 1;
        return q;
    endfunction

    function automatic longint clamp16(input longint v);
        longint hi;
        hi = (longint'(1) << (`VMUL_DIN_WIDTH - 1)) - 1;
        if (v > hi)
            return hi;
        if (v < -hi - 1)
            return -hi - 1;
        return v;
    endfunction

    function automatic longint to_q12(input operand_t v, input point_t pt);
        longint x;
        int     diff;
        x = v;
        diff = `VMUL_ALIGN_FRAC - int'(pt);
        if (diff >= 0)
            return clamp16(x * (longint'(1) << diff));
        return floor_div(x, longint'(1) << -diff);
    endfunction

    function automatic result_vec_t expected_result(input operand_vec_t a, input operand_vec_t b,
                                                    input point_t pa, input point_t pb,
                                                    input round_op_e rop);
        result_vec_t res;
        longint      p;
        for (int i = 0; i < `VMUL_PARALLEL; i++) begin
            p = to_q12(a[i], pa) * to_q12(b[i], pb);
            if (rop == op_round)
                p = p + (longint'(1) << (`VMUL_ALIGN_FRAC - 1));
            res[i] = result_t'(clamp16(floor_div(p, longint'(1) << `VMUL_ALIGN_FRAC)));
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // scoreboard, sampled like a flop.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always @(posedge clk) begin
        cycle_count++;
        if (!rst_n) begin
            exp_q.delete();
            took <= 1'b0;
        end else begin
            took <= in_valid && in_ready;
            if (in_valid && !in_ready)
                stall_cycles++;
            if (in_valid && in_ready)
                exp_q.push_back(expected_result(in_a, in_b, a_point, b_point, op));
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    other_errors++;
                    $display("output transfer at %0t ns with no transfer waiting for it", $time);
                end else begin
                    expected = exp_q.pop_front();
                    assert (out_data == expected) else begin
                        value_errors++;
                        $display("** Error at %0t ns: result %h, expected %h",
                                 $time, out_data, expected);
                    end
                end
            end
        end
    end

    initial begin
        wait (cycle_count >= TIMEOUT_CYCLES);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus, driven on the falling edge.
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic pick(input int mode);
        for (int i = 0; i < `VMUL_PARALLEL; i++) begin
            if (mode == MODE_SMALL) begin
                in_a[i] = operand_t'(($random(seed) % 64) * 64);
                in_b[i] = operand_t'(($random(seed) % 64) * 64);
            end else if (!(mode == MODE_LARGE && repeat_pair)) begin
                in_a[i] = operand_t'($random(seed));
                in_b[i] = operand_t'($random(seed));
            end
        end
        if (mode == MODE_POINTS) begin
            a_point = point_t'($random(seed));
            b_point = point_t'($random(seed));
            op      = round_op_e'($random(seed) & 1);
        end else begin
            a_point = point_t'(`VMUL_ALIGN_FRAC);
            b_point = point_t'(`VMUL_ALIGN_FRAC);
            // same operands twice, once per opcode.
            if (mode == MODE_LARGE) begin
                op          = repeat_pair ? op_trunc : op_round;
                repeat_pair = !repeat_pair;
            end else begin
                op = round_op_e'($random(seed) & 1);
            end
        end
    endtask

    task automatic run_stream(input int count, input int mode, input int ready_pct);
        int sent;
        sent = 0;
        @(negedge clk);
        pick(mode);
        in_valid = 1'b1;
        while (sent < count) begin
            out_ready = ({$random(seed)} % 100) < ready_pct;
            @(negedge clk);
            if (took) begin
                sent++;
                if (sent < count)
                    pick(mode);
                else
                    in_valid = 1'b0;
            end
        end
    endtask

    task automatic wait_idle();
        int waited;
        in_valid  = 1'b0;
        out_ready = 1'b1;
        waited    = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || out_valid) && waited < DRAIN_CYCLES) begin
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic apply_reset();
        @(negedge clk);
        rst_n    = 1'b0;
        in_valid = 1'b0;
        @(negedge clk);
        assert (!out_valid && in_ready) else begin
            value_errors++;
            $display("** Error at %0t ns: in reset out_valid=%b in_ready=%b",
                     $time, out_valid, in_ready);
        end
        @(negedge clk);
        rst_n = 1'b1;
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        in_a        = '0;
        in_b        = '0;
        a_point     = point_t'(`VMUL_ALIGN_FRAC);
        b_point     = point_t'(`VMUL_ALIGN_FRAC);
        op          = op_round;
        out_ready   = 1'b1;
        repeat_pair = 1'b0;
        repeat (2) @(negedge clk);
        rst_n = 1'b1;

        run_stream(100, MODE_SMALL, 100);
        run_stream(120, MODE_POINTS, 100);
        run_stream(80, MODE_LARGE, 100);

        // single transfer through an idle unit.
        wait_idle();
        pick(MODE_POINTS);
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
        latency  = 0;
        while (!out_valid) begin
            @(negedge clk);
            latency++;
        end
        assert (latency == 6) else begin
            value_errors++;
            $display("** Error at %0t ns: latency %0d cycles, expected 6", $time, latency);
        end

        wait_idle();
        stall_cycles = 0;
        run_stream(150, MODE_POINTS, 40);
        if (stall_cycles == 0) begin
            other_errors++;
            $display("in_ready never dropped while the output was stalled");
        end

        // results still in flight are discarded here.
        apply_reset();
        run_stream(50, MODE_POINTS, 70);
        wait_idle();
        repeat (10) @(negedge clk);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("%0d expected results never came out", exp_q.size());
        end

        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/fixed_point_pkg.sv
source/vmul_ctrl_pkg.sv
source/point_align.sv
source/dsp48_mult.sv
source/parallel_mult.sv
source/result_queue.sv
source/vmul_top.sv
sim/vmul_assertions.sv
sim/vmul_tb.sv
